// File: Makefile
# Verilator build and run for the store streamer testbench.

VERILATOR ?= verilator
TOP       ?= sink_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
logic/sink_pkg.sv
logic/sink_fifo.sv
logic/sink_addr_gen.sv
logic/sink_ctrl.sv
logic/sink_top.sv
verification/sink_props.sv
verification/sink_tb.sv

// File: logic/sink_addr_gen.sv
// Two-dimensional store address generator.
// Walks line_len words per line over num_lines lines and tracks progress.

`timescale 1ns/10ps

module sink_addr_gen
  import sink_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              load_i,         // Start of a transfer.
  input  logic              next_i,         // Current address consumed.
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [ADDR_W-1:0] word_stride_i,
  input  logic [ADDR_W-1:0] line_stride_i,
  input  logic [CNT_W-1:0]  line_len_i,
  input  logic [CNT_W-1:0]  num_lines_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              last_o,
  output logic              in_progress_o
);

  logic [CNT_W-1:0]  word_cnt_q;      // Position in the line.
  logic [CNT_W-1:0]  line_cnt_q;      // Line index.
  logic [ADDR_W-1:0] line_addr_q;     // Start of the current line.
  logic [ADDR_W-1:0] cur_addr_q;      // Address on offer.
  logic [ADDR_W-1:0] next_line_addr;
  logic              in_progress_q;
  logic              word_end;
  logic              line_end;
  logic              step;

  assign word_end = (word_cnt_q == line_len_i - 1'b1);  // Last word of line.
  assign line_end = (line_cnt_q == num_lines_i - 1'b1); // Last line.
  assign step     = next_i & in_progress_q;             // Ignore stray next.

  assign next_line_addr = line_addr_q + line_stride_i;

  assign addr_o        = cur_addr_q;
  assign last_o        = in_progress_q & word_end & line_end;
  assign in_progress_o = in_progress_q;

  // ******************************
  // Counters and progress
  // ******************************

  always_ff @(posedge clk_i or negedge rst_ni) begin : cnt_ff
    if (!rst_ni) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      in_progress_q <= 1'b0;
    end else if (clear_i) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      in_progress_q <= 1'b0;
    end else if (load_i) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      // Empty pattern never starts.
      in_progress_q <= (line_len_i != '0) && (num_lines_i != '0);
    end else if (step) begin
      if (last_o) begin
        in_progress_q <= 1'b0;  // Final address gone.
      end else if (word_end) begin
        word_cnt_q <= '0;
        line_cnt_q <= line_cnt_q + 1'b1;
      end else begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  // ******************************
  // Address registers
  // ******************************

  always_ff @(posedge clk_i) begin : addr_ff
    if (load_i) begin
      line_addr_q <= base_addr_i;
      cur_addr_q  <= base_addr_i;
    end else if (step && word_end) begin
      line_addr_q <= next_line_addr;  // Jump to the next line start.
      cur_addr_q  <= next_line_addr;
    end else if (step) begin
      cur_addr_q <= cur_addr_q + word_stride_i;
    end
  end

endmodule

// File: logic/sink_ctrl.sv
// Store streamer controller.
// Pairs stream beats with generated addresses, drains stores, flags done.

`timescale 1ns/10ps

module sink_ctrl
  import sink_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  // Control plane.
  input  logic              req_start_i,
  output logic              ready_start_o,
  output logic              done_o,
  // Input FIFO head.
  input  logic              in_empty_i,
  input  stream_beat_t      in_beat_i,
  output logic              in_pop_o,
  // Address generator.
  input  logic [ADDR_W-1:0] gen_addr_i,
  input  logic              gen_in_progress_i,
  output logic              gen_load_o,
  output logic              gen_next_o,
  // Store FIFO tail.
  input  logic              st_full_i,
  input  logic              st_empty_i,
  output logic              st_push_o,
  output store_req_t        st_req_o,
  // Memory port.
  input  logic              mem_busy_i      // Request still pending.
);

  sink_state_t state_q;
  sink_state_t state_d;
  logic        done_q;
  logic        done_d;
  logic        fire;       // Beat and address move this cycle.

  assign ready_start_o = (state_q == IDLE);
  assign gen_load_o    = ready_start_o & req_start_i;  // Accepted start.
  assign done_o        = done_q;

  // Pair a beat with an address when both sides can move.
  assign fire = (state_q == WORKING) & ~in_empty_i & ~st_full_i & gen_in_progress_i;

  assign in_pop_o   = fire;
  assign st_push_o  = fire;
  assign gen_next_o = fire;

  // Store request from the head beat and the current address.
  always_comb begin : req_build
    st_req_o.addr = gen_addr_i;
    st_req_o.data = in_beat_i.data;
    st_req_o.be   = in_beat_i.strb;
  end

  // ******************************
  // State machine
  // ******************************

  always_comb begin : fsm_comb
    state_d = state_q;
    done_d  = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (req_start_i) begin
          state_d = WORKING;  // Generator loads now.
        end
      end
      WORKING: begin
        // Generator idle means the last address was taken.
        if (!gen_in_progress_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // All stores granted.
        if (st_empty_i && !mem_busy_i) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_ff
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= IDLE;  // Abort, no done.
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;  // One cycle pulse.
    end
  end

endmodule

// File: logic/sink_fifo.sv
// Synchronous FIFO for the store streamer.
// Circular buffer with occupancy count and synchronous flush.

`timescale 1ns/10ps

module sink_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  // Write side.
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  // Read side.
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // Storage.
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [OCC_W-1:0] count_q;        // Entries held.
  logic             push_ok;
  logic             pop_ok;

  assign full_o  = (count_q == OCC_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // Pop only real entries, no fall-through when empty.
  assign pop_ok  = pop_i & ~empty_o;
  // Push into a full FIFO is fine if the head leaves this cycle.
  assign push_ok = push_i & (~full_o | pop_ok);

  // Head comes straight from the storage registers.
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_ff
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin  // Flush drops everything.
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or none.
      endcase
    end
  end

  // Storage write.
  always_ff @(posedge clk_i) begin : mem_ff
    if (push_ok && !clear_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: logic/sink_pkg.sv
// Store streamer shared definitions.
// Bus widths, payload structs and the controller state encoding.

package sink_pkg;

  // ******************************
  // Widths
  // ******************************

  localparam int unsigned ADDR_W = 32;  // Byte address.
  localparam int unsigned DATA_W = 32;  // One memory word.
  localparam int unsigned STRB_W = DATA_W / 8;  // One strobe per byte.

  // Word and line counters of the address pattern.
  localparam int unsigned CNT_W = 16;

  // ******************************
  // Payloads
  // ******************************

  // One beat of the incoming stream.
  typedef struct packed {
    logic [DATA_W-1:0] data;  // Word from the datapath.
    logic [STRB_W-1:0] strb;  // Byte enables of the word.
  } stream_beat_t;

  // One store on the memory port.
  typedef struct packed {
    logic [ADDR_W-1:0] addr;  // Target byte address.
    logic [DATA_W-1:0] data;  // Write data.
    logic [STRB_W-1:0] be;    // Byte enables.
  } store_req_t;

  // ******************************
  // Controller states
  // ******************************

  // IDLE waits for a start.
  // WORKING pairs beats with addresses.
  // DRAIN waits for the last stores to be granted.
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DRAIN   = 2'd2
  } sink_state_t;

endpackage

// File: logic/sink_top.sv
// Store streamer top level.
// Input FIFO, address generator, controller and store FIFO in a chain.

`timescale 1ns/10ps

module sink_top
  import sink_pkg::*;
#(
  parameter int unsigned IN_DEPTH    = 4,
  parameter int unsigned STORE_DEPTH = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  // Transfer configuration.
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [ADDR_W-1:0] word_stride_i,
  input  logic [CNT_W-1:0]  line_len_i,
  input  logic [ADDR_W-1:0] line_stride_i,
  input  logic [CNT_W-1:0]  num_lines_i,
  // Control plane.
  input  logic              req_start_i,
  output logic              ready_start_o,
  output logic              done_o,
  // Input stream.
  input  logic              stream_valid_i,
  input  logic [DATA_W-1:0] stream_data_i,
  input  logic [STRB_W-1:0] stream_strb_i,
  output logic              stream_ready_o,
  // Memory store port.
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_data_o,
  output logic [STRB_W-1:0] mem_be_o,
  input  logic              mem_gnt_i
);

  stream_beat_t      in_beat;      // Incoming beat.
  stream_beat_t      in_head;      // Input FIFO head.
  logic              in_full;
  logic              in_empty;
  logic              in_pop;
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_in_progress;
  logic              gen_load;
  logic              gen_next;
  store_req_t        st_req;       // Store FIFO tail.
  store_req_t        st_head;      // Store FIFO head.
  logic              st_full;
  logic              st_empty;
  logic              st_push;
  logic              st_pop;

  assign in_beat.data   = stream_data_i;
  assign in_beat.strb   = stream_strb_i;
  assign stream_ready_o = ~in_full;

  // Request while anything is queued, pop on grant.
  assign mem_req_o  = ~st_empty;
  assign st_pop     = mem_req_o & mem_gnt_i;
  assign mem_addr_o = st_head.addr;
  assign mem_data_o = st_head.data;
  assign mem_be_o   = st_head.be;

  sink_fifo #(
    .DEPTH     ( IN_DEPTH      ),
    .payload_t ( stream_beat_t )
  ) u_in_fifo (
    .clk_i   ( clk_i                   ),
    .rst_ni  ( rst_ni                  ),
    .clear_i ( clear_i                 ),
    .push_i  ( stream_valid_i          ),
    .data_i  ( in_beat                 ),
    .full_o  ( in_full                 ),
    .pop_i   ( in_pop                  ),
    .data_o  ( in_head                 ),
    .empty_o ( in_empty                )
  );

  sink_addr_gen u_addr_gen (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .clear_i       ( clear_i         ),
    .load_i        ( gen_load        ),
    .next_i        ( gen_next        ),
    .base_addr_i   ( base_addr_i     ),
    .word_stride_i ( word_stride_i   ),
    .line_stride_i ( line_stride_i   ),
    .line_len_i    ( line_len_i      ),
    .num_lines_i   ( num_lines_i     ),
    .addr_o        ( gen_addr        ),
    .last_o        (                 ),
    .in_progress_o ( gen_in_progress )
  );

  sink_ctrl u_ctrl (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .req_start_i       ( req_start_i     ),
    .ready_start_o     ( ready_start_o   ),
    .done_o            ( done_o          ),
    .in_empty_i        ( in_empty        ),
    .in_beat_i         ( in_head         ),
    .in_pop_o          ( in_pop          ),
    .gen_addr_i        ( gen_addr        ),
    .gen_in_progress_i ( gen_in_progress ),
    .gen_load_o        ( gen_load        ),
    .gen_next_o        ( gen_next        ),
    .st_full_i         ( st_full         ),
    .st_empty_i        ( st_empty        ),
    .st_push_o         ( st_push         ),
    .st_req_o          ( st_req          ),
    .mem_busy_i        ( mem_req_o       )
  );

  sink_fifo #(
    .DEPTH     ( STORE_DEPTH ),
    .payload_t ( store_req_t )
  ) u_store_fifo (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .clear_i ( clear_i  ),
    .push_i  ( st_push  ),
    .data_i  ( st_req   ),
    .full_o  ( st_full  ),
    .pop_i   ( st_pop   ),
    .data_o  ( st_head  ),
    .empty_o ( st_empty )
  );

endmodule

// File: verification/sink_props.sv
// Store streamer assertions.
// Memory port stability and done pulse rules, bound into the top level.

`timescale 1ns/10ps

module sink_props
  import sink_pkg::*;
(
  input logic              clk_i,
  input logic              rst_ni,
  input logic              clear_i,
  input logic              mem_req_i,
  input logic              mem_gnt_i,
  input logic [ADDR_W-1:0] mem_addr_i,
  input logic [DATA_W-1:0] mem_data_i,
  input logic [STRB_W-1:0] mem_be_i,
  input logic              done_i,
  input logic              st_empty_i,
  input sink_state_t       state_i
);

  int unsigned fail_cnt = 0;  // Failed assertions so far.

  // Request and fields hold until granted, unless flushed.
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_gnt_i && !clear_i |=> mem_req_i && $stable(mem_addr_i)
      && $stable(mem_data_i) && $stable(mem_be_i))
    else begin
      fail_cnt++;
      $error("Store request changed before grant.");
    end

  done_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o longer than one cycle.");
    end

  done_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> st_empty_i)
    else begin
      fail_cnt++;
      $error("done_o with stores still queued.");
    end

  // Idle after done or flush leaves the port quiet.
  idle_quiet_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == IDLE |-> !mem_req_i)
    else begin
      fail_cnt++;
      $error("Store request while the controller is idle.");
    end

endmodule

bind sink_top sink_props u_props (
  .clk_i      ( clk_i          ),
  .rst_ni     ( rst_ni         ),
  .clear_i    ( clear_i        ),
  .mem_req_i  ( mem_req_o      ),
  .mem_gnt_i  ( mem_gnt_i      ),
  .mem_addr_i ( mem_addr_o     ),
  .mem_data_i ( mem_data_o     ),
  .mem_be_i   ( mem_be_o       ),
  .done_i     ( done_o         ),
  .st_empty_i ( st_empty       ),
  .state_i    ( u_ctrl.state_q )
);

// File: verification/sink_tb.sv
// Store streamer testbench.
// Streams beats through the DUT and checks every granted store.

`timescale 1ns/10ps

module sink_tb
  import sink_pkg::*;
;
  localparam int unsigned TOTAL_WORDS = 146;  // All tests together.
  localparam int unsigned LIMIT = 20 * TOTAL_WORDS + 1000;

  logic clk_i = 1'b0, rst_ni, clear_i, req_start_i, ready_start_o, done_o;
  logic [ADDR_W-1:0] base_addr_i, word_stride_i, line_stride_i;
  logic [CNT_W-1:0]  line_len_i, num_lines_i;
  logic stream_valid_i, stream_ready_o, mem_req_o, mem_gnt_i;
  logic [DATA_W-1:0] stream_data_i, mem_data_o;
  logic [STRB_W-1:0] stream_strb_i, mem_be_o;
  logic [ADDR_W-1:0] mem_addr_o;

  integer seed = 32'h633b4b45;
  string  test_name = "reset";
  int     gnt_pct = 100, done_cnt = 0, cycle_cnt = 0;
  logic   ready_low_seen = 1'b0;
  logic [CNT_W-1:0]  exp_words = '0, stores_seen = '0;
  logic [ADDR_W-1:0] exp_addr_q[$];
  logic [DATA_W-1:0] exp_data_q[$];
  logic [STRB_W-1:0] exp_be_q[$];

  sink_top #(.IN_DEPTH(4), .STORE_DEPTH(2)) u_sink_top (.*);

  initial begin
    forever #5 clk_i = ~clk_i;  // 10 ns period.
  end

  // Address rule: line = k / len, word = k % len.
  function automatic logic [ADDR_W-1:0] expected_addr(input int unsigned k);
    int unsigned len;
    len = 32'(line_len_i);
    return base_addr_i + ADDR_W'(k / len) * line_stride_i + ADDR_W'(k % len) * word_stride_i;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s (test %s)", msg, test_name);
    $display("TEST FAILED");
    $fatal(1, "Run stopped.");
  endtask

  task automatic check_store(input logic [ADDR_W-1:0] ea, aa, input logic [DATA_W-1:0] ed, ad,
                             input logic [STRB_W-1:0] eb, ab);
    if (ea !== aa || ed !== ad || eb !== ab) begin
      $display("CHECK FAILED %s: expected addr %h data %h be %h, actual addr %h data %h be %h",
               test_name, ea, ed, eb, aa, ad, ab);
      fail_run("Store mismatch");
    end
  endtask

  task automatic check_count(input logic [CNT_W-1:0] exp, act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %0d stores, actual %0d", test_name, exp, act);
      fail_run("Store count mismatch");
    end
  endtask

  // No request may show up for n cycles.
  task automatic quiet_check(input int n);
    repeat (n) begin
      @(negedge clk_i);
      if (mem_req_o) fail_run("mem_req_o rose while no transfer was active");
    end
  endtask

  task automatic run_transfer(input string name, input logic [ADDR_W-1:0] base, wstride,
                              lstride, input logic [CNT_W-1:0] llen, nlines,
                              input int unsigned send_n, input int gap_pct,
                              input bit rnd_strb, input bit wait_end);
    int unsigned k;
    int          prev_done;
    logic [31:0] rnd;
    k = 0;
    @(negedge clk_i);
    test_name     = name;
    base_addr_i   = base;
    word_stride_i = wstride;
    line_stride_i = lstride;
    line_len_i    = llen;
    num_lines_i   = nlines;
    exp_words     = llen * nlines;
    if (!ready_start_o) fail_run("ready_start_o was low when a transfer was due");
    prev_done   = done_cnt;
    req_start_i = 1'b1;
    while (k < send_n) begin
      @(negedge clk_i);
      req_start_i = 1'b0;
      rnd = $random(seed);
      // Raise valid only when ready, so it never drops before a transfer.
      if ((rnd % 100) < gap_pct || !stream_ready_o) begin
        stream_valid_i = 1'b0;
      end else begin
        stream_valid_i = 1'b1;
        stream_data_i  = $random(seed);
        stream_strb_i  = rnd_strb ? rnd[11:8] : 4'hF;
        exp_addr_q.push_back(expected_addr(k));
        exp_data_q.push_back(stream_data_i);
        exp_be_q.push_back(stream_strb_i);
        k++;
      end
    end
    @(negedge clk_i);
    stream_valid_i = 1'b0;
    req_start_i    = 1'b0;
    while (wait_end && done_cnt == prev_done) @(negedge clk_i);
  endtask

  // ******************************
  // Memory model and compare
  // ******************************

  always @(negedge clk_i) mem_gnt_i <= ($unsigned($random(seed)) % 100) < gnt_pct;

  always @(posedge clk_i) begin : compare
    if (rst_ni) begin
      if (!stream_ready_o) ready_low_seen = 1'b1;
      if (mem_req_o && mem_gnt_i) begin
        if (exp_addr_q.size() == 0) fail_run("A store was granted with no word expected");
        check_store(exp_addr_q.pop_front(), mem_addr_o, exp_data_q.pop_front(), mem_data_o,
                    exp_be_q.pop_front(), mem_be_o);
        stores_seen++;
      end
      if (done_o) begin
        check_count(exp_words, stores_seen);
        stores_seen = '0;
        done_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout: the run took more than %0d cycles in test %s", LIMIT, test_name);
      $display("TEST FAILED");
      $fatal(1, "Timeout.");
    end
  end

  // ******************************
  // Test sequence
  // ******************************

  initial begin : main
    int prev_done;
    {rst_ni, clear_i, req_start_i, stream_valid_i} = '0;
    {base_addr_i, word_stride_i, line_stride_i, line_len_i, num_lines_i} = '0;
    {stream_data_i, stream_strb_i} = '0;
    mem_gnt_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (mem_req_o || done_o || !ready_start_o || !stream_ready_o)
      fail_run("Outputs after reset were not idle");
    run_transfer("linear", 32'h1000, 4, 64, 16, 1, 16, 0, 0, 1);
    run_transfer("two_dim", 32'h2000, 4, 32'h100, 5, 4, 20, 0, 0, 1);
    gnt_pct = 25;  // Heavy stalls fill both FIFOs.
    ready_low_seen = 1'b0;
    run_transfer("stalls", 32'h4000, 8, 32'h200, 8, 5, 40, 30, 0, 1);
    if (!ready_low_seen) fail_run("stream_ready_o never fell while stores were stalled");
    gnt_pct = 60;
    run_transfer("strobes", 32'h6000, 4, 32'h80, 6, 4, 24, 20, 1, 1);
    if (!ready_start_o) fail_run("ready_start_o was low after done");
    gnt_pct = 100;
    quiet_check(8);
    run_transfer("back_to_back", 32'h8000, 12, 32'h300, 3, 4, 12, 10, 1, 1);
    // Abort halfway with clear.
    gnt_pct = 30;
    prev_done = done_cnt;
    run_transfer("clear", 32'hA000, 4, 32'h100, 4, 4, 6, 0, 0, 0);
    repeat (3) @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_be_q.delete();
    stores_seen = '0;
    if (!ready_start_o) fail_run("ready_start_o stayed low after clear");
    quiet_check(10);
    if (done_cnt != prev_done) fail_run("done_o pulsed after clear");
    gnt_pct = 100;
    run_transfer("clean_linear", 32'hC000, 4, 64, 16, 1, 16, 0, 0, 1);
    run_transfer("clean_two_dim", 32'hD000, 4, 32'h40, 4, 3, 12, 0, 0, 1);
    if (u_sink_top.u_props.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
